//--- rtl/hdc_pkg.sv
package hdc_pkg;

    // hypervector geometry
    localparam int DIM          = 128;
    localparam int WORD_W       = 32;
    localparam int WORDS_PER_HV = 4;
    localparam int WORD_IDX_W   = 2;

    // item memory
    localparam int ITEMS   = 64;
    localparam int ADDR_W  = 6;
    localparam int COUNT_W = 7;

    // instruction fields
    localparam int ROT_W  = 7;
    localparam int OPND_W = 9;

    // xorshift must never start from zero
    localparam logic [WORD_W-1:0] DEFAULT_SEED = 32'h2545_f491;

    // apb register map
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;
    localparam logic [APB_AW-1:0] REG_CTRL   = 4'h0;
    localparam logic [APB_AW-1:0] REG_SEED   = 4'h4;
    localparam logic [APB_AW-1:0] REG_COUNT  = 4'h8;
    localparam logic [APB_AW-1:0] REG_STATUS = 4'hc;

    typedef logic [DIM-1:0] hv_t;

    // codes 8 to 15 are treated as nop
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_LOAD  = 4'h1,
        OP_BIND  = 4'h2,
        OP_PERM  = 4'h3,
        OP_MOVE  = 4'h4,
        OP_STORE = 4'h5,
        OP_WB    = 4'h6,
        OP_LAST  = 4'h7
    } opcode_e;

    typedef struct packed {
        opcode_e             op;
        logic [2:0]          rsvd;
        logic [OPND_W-1:0]   operand;
    } instr_t;

    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [APB_AW-1:0]   paddr;
        logic [APB_DW-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0]   prdata;
        logic                pready;
        logic                pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [WORD_W-1:0]   seed;
        logic [COUNT_W-1:0]  count;
        logic                start;
    } gen_cfg_t;

    typedef struct packed {
        logic                en;
        logic [ADDR_W-1:0]   addr;
        hv_t                 data;
    } mem_wr_t;

endpackage

//--- rtl/hdc_apb_regs.sv
module hdc_apb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  hdc_pkg::apb_req_t  apb_req,
    input  logic               busy,
    input  logic               done,
    output hdc_pkg::apb_rsp_t  apb_rsp,
    output hdc_pkg::gen_cfg_t  gen_cfg
);
    import hdc_pkg::*;

    logic                access;
    logic                mapped;
    logic                slverr;
    logic                wr_ok;
    logic [APB_DW-1:0]   rdata;
    logic [WORD_W-1:0]   seed_q;
    logic [COUNT_W-1:0]  count_q;
    logic                start_q;

    // access phase without wait states
    assign access = apb_req.psel & apb_req.penable;

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (apb_req.paddr)
            REG_CTRL:   rdata = '0;
            REG_SEED:   rdata = seed_q;
            REG_COUNT:  rdata = {{(APB_DW - COUNT_W){1'b0}}, count_q};
            REG_STATUS: rdata = {{(APB_DW - 2){1'b0}}, done, busy};
            default:    mapped = 1'b0;
        endcase
    end

    // status is read only
    assign slverr = ~mapped | (apb_req.pwrite & (apb_req.paddr == REG_STATUS));
    assign wr_ok  = access & apb_req.pwrite & ~slverr;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & slverr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seed_q  <= '0;
            count_q <= COUNT_W'(ITEMS);
            start_q <= 1'b0;
        end else begin
            // start is a single cycle pulse
            start_q <= wr_ok & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0];
            if (wr_ok && apb_req.paddr == REG_SEED) begin
                seed_q <= apb_req.pwdata;
            end
            if (wr_ok && apb_req.paddr == REG_COUNT) begin
                count_q <= apb_req.pwdata[COUNT_W-1:0];
            end
        end
    end

    assign gen_cfg.seed  = seed_q;
    assign gen_cfg.count = count_q;
    assign gen_cfg.start = start_q;

endmodule

//--- rtl/hdc_item_gen.sv
module hdc_item_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  hdc_pkg::gen_cfg_t  gen_cfg,
    output hdc_pkg::mem_wr_t   gen_wr,
    output logic               busy,
    output logic               done
);
    import hdc_pkg::*;

    logic [WORD_W-1:0]      xs_q;
    logic [WORD_W-1:0]      xs_next;
    logic [WORD_IDX_W-1:0]  word_idx;
    logic [ADDR_W-1:0]      item_addr;
    logic [COUNT_W-1:0]     count_q;
    hv_t                    hv_q;
    logic                   last_item;

    function automatic logic [WORD_W-1:0] xorshift32(input logic [WORD_W-1:0] s);
        logic [WORD_W-1:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign xs_next = xorshift32(xs_q);

    // top word goes straight from the generator into the write
    always_comb begin
        gen_wr.en   = busy && (word_idx == WORD_IDX_W'(WORDS_PER_HV - 1));
        gen_wr.addr = item_addr;
        gen_wr.data = hv_q;
        gen_wr.data[WORD_W*(WORDS_PER_HV-1) +: WORD_W] = xs_next;
    end

    // also stops at the end of the memory
    assign last_item = ({1'b0, item_addr} == count_q - 1'b1) ||
                       (item_addr == ADDR_W'(ITEMS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            word_idx  <= '0;
            item_addr <= '0;
        end else if (gen_cfg.start) begin
            busy      <= 1'b1;
            done      <= 1'b0;
            word_idx  <= '0;
            item_addr <= '0;
        end else if (busy) begin
            word_idx <= word_idx + 1'b1;
            if (gen_wr.en) begin
                item_addr <= item_addr + 1'b1;
                if (last_item) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gen_cfg.start) begin
            xs_q    <= (gen_cfg.seed == '0) ? DEFAULT_SEED : gen_cfg.seed;
            count_q <= gen_cfg.count;
        end else if (busy) begin
            xs_q <= xs_next;
            // lsw first
            hv_q[word_idx*WORD_W +: WORD_W] <= xs_next;
        end
    end

endmodule

//--- rtl/hdc_item_mem.sv
module hdc_item_mem (
    input  logic                        clk,
    input  hdc_pkg::mem_wr_t            gen_wr,
    input  hdc_pkg::mem_wr_t            exec_wr,
    input  logic [hdc_pkg::ADDR_W-1:0]  rd_addr,
    output hdc_pkg::hv_t                rd_data
);
    import hdc_pkg::*;

    hv_t      mem [ITEMS];
    mem_wr_t  wr;

    // generator has priority over write-back
    always_comb begin
        if (gen_wr.en) begin
            wr = gen_wr;
        end else begin
            wr = exec_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read with same-edge write forwarding
    always_ff @(posedge clk) begin
        if (wr.en && wr.addr == rd_addr) begin
            rd_data <= wr.data;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- rtl/hdc_exec.sv
module hdc_exec (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  hdc_pkg::instr_t             instr,
    input  hdc_pkg::hv_t                rd_data,
    output logic [hdc_pkg::ADDR_W-1:0]  rd_addr,
    output hdc_pkg::mem_wr_t            exec_wr,
    output hdc_pkg::hv_t                result,
    output logic                        result_valid,
    output logic                        last
);
    import hdc_pkg::*;

    logic                s1_valid;
    opcode_e             s1_op;
    logic [ROT_W-1:0]    s1_arg;
    hv_t                 reg1;
    hv_t                 reg2;
    logic [2*DIM-1:0]    rot_dbl;
    hv_t                 reg2_rot;

    // memory samples the address at the edge that accepts the instruction
    assign rd_addr = instr.operand[ADDR_W-1:0];

    // stage 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            s1_op  <= instr.op;
            s1_arg <= instr.operand[ROT_W-1:0];
        end
    end

    // rotate left by an amount already modulo DIM
    assign rot_dbl  = {reg2, reg2} << s1_arg;
    assign reg2_rot = rot_dbl[2*DIM-1:DIM];

    // write-back lands together with the next instruction's read
    assign exec_wr.en   = s1_valid && (s1_op == OP_WB);
    assign exec_wr.addr = s1_arg[ADDR_W-1:0];
    assign exec_wr.data = reg2;

    // stage 2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg1         <= '0;
            reg2         <= '0;
            result_valid <= 1'b0;
            last         <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            last         <= 1'b0;
            if (s1_valid) begin
                case (s1_op)
                    OP_LOAD:  reg2 <= rd_data;
                    OP_BIND:  reg2 <= reg1 ^ reg2;
                    OP_PERM:  reg2 <= reg2_rot;
                    OP_MOVE:  reg1 <= reg2;
                    OP_STORE: result_valid <= 1'b1;
                    OP_LAST:  last <= 1'b1;
                    // nop, wb and undefined codes keep both registers
                    default:  ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s1_op == OP_STORE) begin
            result <= reg2;
        end
    end

endmodule

//--- rtl/hdc_core_top.sv
module hdc_core_top (
    input  logic               clk,
    input  logic               rst_n,
    input  hdc_pkg::apb_req_t  apb_req,
    input  logic               instr_valid,
    input  hdc_pkg::instr_t    instr,
    output hdc_pkg::apb_rsp_t  apb_rsp,
    output hdc_pkg::hv_t       result,
    output logic               result_valid,
    output logic               last,
    output logic               gen_busy,
    output logic               gen_done
);
    import hdc_pkg::*;

    gen_cfg_t           gen_cfg;
    mem_wr_t            gen_wr;
    mem_wr_t            exec_wr;
    logic [ADDR_W-1:0]  rd_addr;
    hv_t                rd_data;

    hdc_apb_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .busy    (gen_busy),
        .done    (gen_done),
        .apb_rsp (apb_rsp),
        .gen_cfg (gen_cfg)
    );

    hdc_item_gen u_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .gen_cfg (gen_cfg),
        .gen_wr  (gen_wr),
        .busy    (gen_busy),
        .done    (gen_done)
    );

    hdc_item_mem u_mem (
        .clk     (clk),
        .gen_wr  (gen_wr),
        .exec_wr (exec_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    hdc_exec u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .exec_wr      (exec_wr),
        .result       (result),
        .result_valid (result_valid),
        .last         (last)
    );

endmodule

//--- verif/hdc_assertions.sv
module hdc_assertions (
    input logic               clk,
    input logic               rst_n,
    input hdc_pkg::apb_req_t  apb_req,
    input hdc_pkg::apb_rsp_t  apb_rsp,
    input logic               instr_valid,
    input logic               result_valid,
    input logic               last,
    input logic               gen_busy,
    input logic               gen_done
);

    // generator owns the memory while busy
    no_instr_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_valid && gen_busy))
        else $error("instruction accepted while the generator is busy");

    store_last_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid && last))
        else $error("result_valid and last high together");

    // no wait states
    ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else $error("pready low in the access phase");

    busy_fall_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gen_busy) == $rose(gen_done))
        else $error("busy fall and done rise are not in the same cycle");

endmodule

bind hdc_core_top hdc_assertions u_assertions (.*);

//--- verif/hdc_tb.sv
module hdc_tb;
    import hdc_pkg::*;

    localparam int MAX_ITEMS = 64;
    localparam int N_RAND    = 60;
    localparam int N_WB      = 4;
    localparam int N_NOP     = 12;
    localparam int N_APB     = 12;
    // generation, all instruction streams, apb traffic, then margin
    localparam int WATCHDOG_CYCLES = MAX_ITEMS * 4 + 2 * MAX_ITEMS + N_RAND + 8 * N_WB
                                     + N_NOP + 3 * N_APB + 200;

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic      instr_valid;
    instr_t    instr;
    hv_t       result;
    logic      result_valid;
    logic      last;
    logic      gen_busy;
    logic      gen_done;

    int   seed = 63;
    int   gen_count;
    int   error_count = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   errors_at_start = 0;
    int   last_seen = 0;
    hv_t  exp_q[$];
    hv_t  model_mem [MAX_ITEMS];
    hv_t  m_reg1 = '0;
    hv_t  m_reg2 = '0;

    hdc_core_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    task automatic check(input string name, input logic [DIM-1:0] got,
                         input logic [DIM-1:0] exp);
        if (got !== exp) begin
            $display("error %s: got %0h expected %0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count != errors_at_start) tests_failed++;
        $display("test %0d %s: %s", tests_run, name,
                 (error_count == errors_at_start) ? "ok" : "failed");
        errors_at_start = error_count;
    endtask

    // one xorshift step with shifts 13, 17 and 5
    function automatic logic [31:0] xs_step(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    task automatic model_generate(input logic [31:0] s, input int n);
        logic [31:0] st;
        st = s;
        for (int i = 0; i < n; i++) begin
            for (int w = 0; w < 4; w++) begin
                st = xs_step(st);
                model_mem[i][w*32 +: 32] = st;
            end
        end
    endtask

    // reference model of one instruction returning the new reg2
    function automatic hv_t ref_exec(input logic [3:0] op, input logic [8:0] operand);
        int amt;
        amt = operand[6:0];
        case (op)
            OP_LOAD: m_reg2 = model_mem[operand[5:0]];
            OP_BIND: m_reg2 = m_reg1 ^ m_reg2;
            OP_PERM: if (amt != 0) m_reg2 = (m_reg2 << amt) | (m_reg2 >> (DIM - amt));
            OP_MOVE: m_reg1 = m_reg2;
            OP_WB:   model_mem[operand[5:0]] = m_reg2;
            default: ;
        endcase
        return m_reg2;
    endfunction

    function automatic int pick_addr();
        return $unsigned($random(seed)) % gen_count;
    endfunction

    task automatic send(input logic [3:0] code, input logic [8:0] operand);
        hv_t exp;
        @(negedge clk);
        instr_valid = 1'b1;
        instr = {code, 3'b000, operand};
        exp = ref_exec(code, operand);
        if (code == OP_STORE) exp_q.push_back(exp);
    endtask

    task automatic drain();
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_rdata, input logic exp_err);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        check("pready", apb_rsp.pready, 1'b1);
        check("pslverr", apb_rsp.pslverr, exp_err);
        if (!wr) check("prdata", apb_rsp.prdata, exp_rdata);
        @(negedge clk);
        apb_req = '0;
    endtask

    // compare results at the falling edge, where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (result_valid && exp_q.size() == 0) begin
                $display("result_valid went high with no store outstanding");
                error_count++;
            end else if (result_valid) begin
                check("result", result, exp_q.pop_front());
            end
            if (last) begin
                last_seen++;
                if (result_valid) begin
                    $display("last and result_valid were high in the same cycle");
                    error_count++;
                end
            end
        end
    end

    initial begin
        int a;
        int b;
        logic [3:0] code;
        rst_n = 1'b0;
        apb_req = '0;
        instr_valid = 1'b0;
        instr = '0;
        gen_count = 2 + ($unsigned($random(seed)) % (MAX_ITEMS - 1));
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        apb_access(1'b0, REG_STATUS, 0, 0, 1'b0);
        apb_access(1'b1, REG_SEED, 32'd63, 0, 1'b0);
        apb_access(1'b0, REG_SEED, 0, 32'd63, 1'b0);
        apb_access(1'b1, REG_COUNT, gen_count, 0, 1'b0);
        apb_access(1'b0, REG_COUNT, 0, gen_count, 1'b0);
        apb_access(1'b0, 4'h3, 0, 0, 1'b1);
        apb_access(1'b1, REG_STATUS, 32'h3, 0, 1'b1);
        apb_access(1'b0, REG_STATUS, 0, 0, 1'b0);
        end_test("register access");

        apb_access(1'b1, REG_CTRL, 32'h1, 0, 1'b0);
        // first cycle after the start pulse
        @(negedge clk);
        check("gen_busy", gen_busy, 1'b1);
        check("gen_done", gen_done, 1'b0);
        while (!gen_done) @(negedge clk);
        check("gen_busy", gen_busy, 1'b0);
        apb_access(1'b0, REG_STATUS, 0, 32'h2, 1'b0);
        model_generate(32'd63, gen_count);
        for (int i = 0; i < gen_count; i++) begin
            send(OP_LOAD, 9'(i));
            send(OP_STORE, '0);
        end
        drain();
        end_test("generation");

        send(OP_LOAD, 9'(pick_addr()));
        send(OP_MOVE, '0);
        send(OP_LOAD, 9'(pick_addr()));
        for (int i = 0; i < N_RAND; i++) begin
            case ($unsigned($random(seed)) % 5)
                0: send(OP_BIND, '0);
                1: send(OP_PERM, 9'($random(seed)));
                2: send(OP_MOVE, '0);
                3: send(OP_STORE, '0);
                default: send(OP_LOAD, 9'(pick_addr()));
            endcase
        end
        send(OP_STORE, '0);
        drain();
        end_test("bind move permute");

        // b is always a different generated address than a
        for (int i = 0; i < N_WB; i++) begin
            a = pick_addr();
            b = (a + 1) % gen_count;
            send(OP_LOAD, 9'(b));
            send(OP_PERM, 9'($random(seed)));
            send(OP_BIND, '0);
            send(OP_WB, 9'(a));
            send(OP_LOAD, 9'(a));
            send(OP_STORE, '0);
            send(OP_LOAD, 9'(b));
            send(OP_STORE, '0);
        end
        drain();
        end_test("write-back");

        a = last_seen;
        send(OP_LAST, '0);
        drain();
        @(posedge clk);
        check("last_pulses", last_seen - a, 1);
        for (int i = 0; i < N_NOP; i++) begin
            code = (i % 2 == 0) ? 4'(OP_NOP) : 4'(8 + ($unsigned($random(seed)) % 8));
            send(code, 9'($random(seed)));
        end
        // reg2 directly, then reg1 through a bind
        send(OP_STORE, '0);
        send(OP_BIND, '0);
        send(OP_STORE, '0);
        drain();
        end_test("last and nop");

        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared on the result port", exp_q.size());
            error_count++;
        end
        $display("summary: %0d tests run, %0d failing, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
rtl/hdc_pkg.sv
rtl/hdc_apb_regs.sv
rtl/hdc_item_gen.sv
rtl/hdc_item_mem.sv
rtl/hdc_exec.sv
rtl/hdc_core_top.sv
verif/hdc_assertions.sv
verif/hdc_tb.sv

//--- Bender.yml
package:
  name: hdc_core

sources:
  - rtl/hdc_pkg.sv
  - rtl/hdc_apb_regs.sv
  - rtl/hdc_item_gen.sv
  - rtl/hdc_item_mem.sv
  - rtl/hdc_exec.sv
  - rtl/hdc_core_top.sv
  - target: test
    files:
      - verif/hdc_assertions.sv
      - verif/hdc_tb.sv
